// ==== Makefile ====
obj_dir/Vmemory_game_tb: sim.f $(wildcard source/*.sv tests/*.sv)
	verilator --binary --timing -Wno-fatal --top-module memory_game_tb -f sim.f

.PHONY: run clean

run: obj_dir/Vmemory_game_tb
	./obj_dir/Vmemory_game_tb > sim.log
	cat sim.log
	! grep -qF '*** TEST FAILED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim.f ====
source/game_pkg.sv
source/display_pkg.sv
source/key_decoder.sv
source/level_store.sv
source/game_controller.sv
source/display_driver.sv
source/memory_game.sv
tests/clock_gen.sv
tests/memory_game_tb.sv

// ==== source/display_driver.sv ====
`timescale 1ns/1ps

module display_driver
    import game_pkg::*, display_pkg::*;
(
    input game_status_t status,
    output display_t hex
);

    function automatic segments_t hex_digit(input level_num_t value);
        case (value)
            4'h0: return hex_0;
            4'h1: return hex_1;
            4'h2: return hex_2;
            4'h3: return hex_3;
            4'h4: return hex_4;
            4'h5: return hex_5;
            4'h6: return hex_6;
            4'h7: return hex_7;
            4'h8: return hex_8;
            4'h9: return hex_9;
            4'ha: return hex_a;
            4'hb: return hex_b;
            4'hc: return hex_c;
            4'hd: return hex_d;
            4'he: return hex_e;
            default: return hex_f;
        endcase
    endfunction

    always_comb
    begin
        case (status.state)
            idle:
                hex = {pat_h, pat_e, pat_l, pat_l, pat_o, pat_blank};
            play:
                hex = {pat_s, pat_small_t, pat_a, pat_g, pat_e, hex_digit(status.level)};
            listen:
                hex = {pat_u, pat_small_r, pat_small_t, pat_u, pat_small_r, pat_small_n};
            won:
                hex = {pat_s, pat_c, pat_o, pat_small_r, pat_e, pat_blank};
            lost:
                hex = {pat_l, pat_o, pat_s, pat_e, pat_blank, pat_blank};
            default:
                hex = {6{pat_blank}};
        endcase
    end

endmodule

// ==== source/display_pkg.sv ====
package display_pkg;

    // active low in bit order gfedcba
    typedef logic [6:0] segments_t;

    // index 5 is the leftmost digit
    typedef segments_t [5:0] display_t;

    localparam segments_t hex_0 = 7'b100_0000;
    localparam segments_t hex_1 = 7'b111_1001;
    localparam segments_t hex_2 = 7'b010_0100;
    localparam segments_t hex_3 = 7'b011_0000;
    localparam segments_t hex_4 = 7'b001_1001;
    localparam segments_t hex_5 = 7'b001_0010;
    localparam segments_t hex_6 = 7'b000_0010;
    localparam segments_t hex_7 = 7'b111_1000;
    localparam segments_t hex_8 = 7'b000_0000;
    localparam segments_t hex_9 = 7'b001_1000;
    localparam segments_t hex_a = 7'b000_1000;
    localparam segments_t hex_b = 7'b000_0011;
    localparam segments_t hex_c = 7'b100_0110;
    localparam segments_t hex_d = 7'b010_0001;
    localparam segments_t hex_e = 7'b000_0110;
    localparam segments_t hex_f = 7'b000_1110;

    // letters that look like digits reuse them
    localparam segments_t pat_o = hex_0;
    localparam segments_t pat_s = hex_5;
    localparam segments_t pat_g = hex_9;
    localparam segments_t pat_a = hex_a;
    localparam segments_t pat_c = hex_c;
    localparam segments_t pat_e = hex_e;

    localparam segments_t pat_h = 7'b000_1001;
    localparam segments_t pat_l = 7'b100_0111;
    localparam segments_t pat_u = 7'b100_0001;
    localparam segments_t pat_small_t = 7'b000_0111;
    localparam segments_t pat_small_r = 7'b100_1110;
    localparam segments_t pat_small_n = 7'b100_1000;
    localparam segments_t pat_blank = 7'b111_1111;

endpackage

// ==== source/game_controller.sv ====
`timescale 1ns/1ps

module game_controller
    import game_pkg::*;
#(
    parameter int note_period = 8,
    parameter int pause_cycles = 16
)
(
    input logic clk,
    input logic load,
    input logic start,
    input key_event_t key_event,
    input level_t level,
    input level_num_t level_num,
    output logic next_level,
    output logic fetch_level,
    output note_t leds,
    output game_status_t status
);

    // one step is a note followed by an equal gap
    localparam int step_cycles = 2 * note_period;
    localparam int timer_max = (step_cycles > pause_cycles) ? step_cycles : pause_cycles;
    localparam int timer_w = $clog2(timer_max + 1);
    localparam logic [timer_w-1:0] step_last = timer_w'(step_cycles - 1);
    localparam logic [timer_w-1:0] pause_last = timer_w'(pause_cycles - 1);
    localparam logic [timer_w-1:0] note_cycles = timer_w'(note_period);
    localparam logic [2:0] first_slot = 3'(max_notes - 1);

    game_state_t state;
    logic [2:0] note_idx;
    logic [timer_w-1:0] timer;
    note_t [max_notes-1:0] expect_q;
    note_t play_note;
    logic last_note;
    logic key_match;

    assign play_note = level.notes[first_slot - note_idx];
    assign last_note = (note_idx == level.length - 3'd1);
    assign key_match = (key_event.note == expect_q[max_notes-1]);

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
        begin
            state <= idle;
            note_idx <= '0;
            timer <= '0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (start)
                        state <= select;
                end
                select:
                    state <= fetch;
                fetch:
                begin
                    note_idx <= '0;
                    timer <= '0;
                    state <= play;
                end
                play:
                begin
                    if (timer == step_last)
                    begin
                        timer <= '0;
                        if (last_note)
                        begin
                            note_idx <= '0;
                            state <= listen;
                        end
                        else
                            note_idx <= note_idx + 3'd1;
                    end
                    else
                        timer <= timer + 1'b1;
                end
                listen:
                begin
                    if (key_event.valid)
                    begin
                        if (!key_match)
                            state <= lost;
                        else if (last_note)
                        begin
                            timer <= '0;
                            state <= won;
                        end
                        else
                            note_idx <= note_idx + 3'd1;
                    end
                end
                won:
                begin
                    if (timer == pause_last)
                    begin
                        timer <= '0;
                        state <= select;
                    end
                    else
                        timer <= timer + 1'b1;
                end
                lost:
                    state <= lost;
                default:
                    state <= idle;
            endcase
        end
    end

    // expected notes loaded as playback ends
    always_ff @(posedge clk)
    begin
        if (state == play && timer == step_last && last_note)
            expect_q <= level.notes;
        else if (state == listen && key_event.valid && key_match)
            expect_q <= {expect_q[max_notes-2:0], note_t'(0)};
    end

    always_comb
    begin
        case (state)
            play:
                leds = (timer < note_cycles) ? play_note : '0;
            won:
                leds = '0;
            default:
                leds = key_event.note;
        endcase
    end

    assign next_level = (state == select);
    assign fetch_level = (state == fetch);
    assign status = {state, level_num};

endmodule

// ==== source/game_pkg.sv ====
package game_pkg;

    localparam int max_notes = 6;

    // one bit per key or LED
    typedef logic [3:0] note_t;

    typedef enum logic [2:0]
    {
        idle,
        select,
        fetch,
        play,
        listen,
        won,
        lost
    } game_state_t;

    typedef logic [3:0] level_num_t;

    // first note sits in the top slot
    typedef struct packed
    {
        logic [2:0] length;
        note_t [max_notes-1:0] notes;
    } level_t;

    // one nibble per note and zero in unused slots
    localparam level_t fixed_levels [1:3] = '{
        {3'd4, 24'h1248_00},
        {3'd5, 24'h1221_10},
        {3'd6, 24'h4214_21}
    };

    typedef struct packed
    {
        logic valid;
        note_t note;
    } key_event_t;

    typedef struct packed
    {
        game_state_t state;
        level_num_t level;
    } game_status_t;

endpackage

// ==== source/key_decoder.sv ====
`timescale 1ns/1ps

module key_decoder
    import game_pkg::*;
(
    input logic clk,
    input logic load,
    input note_t keys,
    output key_event_t key_event
);

    note_t sync_a;
    note_t sync_b;
    note_t prev_keys;
    logic press;

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
        begin
            sync_a <= '0;
            sync_b <= '0;
            prev_keys <= '0;
            press <= 1'b0;
        end
        else
        begin
            sync_a <= keys;
            sync_b <= sync_a;
            prev_keys <= sync_b;
            // released to pressed only
            press <= (sync_b != '0) && (prev_keys == '0);
        end
    end

    assign key_event = {press, prev_keys};

endmodule

// ==== source/level_store.sv ====
`timescale 1ns/1ps

module level_store
    import game_pkg::*;
(
    input logic clk,
    input logic load,
    input level_num_t level_select,
    input logic next_level,
    input logic fetch_level,
    output level_num_t level_num,
    output level_t level
);

    logic [15:0] lfsr;
    note_t [max_notes-1:0] random_notes;

    function automatic note_t to_note(input logic [1:0] bits);
        return note_t'(4'b0001 << bits);
    endfunction

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            level_num <= level_select;
        else if (next_level && level_num != 4'd15)
            level_num <= level_num + 4'd1;
    end

    // free running with taps x^16 + x^14 + x^13 + x^11
    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            lfsr <= 16'hace1;
        else
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    end

    always_ff @(posedge clk)
    begin
        if (next_level)
        begin
            for (int i = 0; i < max_notes; i++)
                random_notes[i] <= to_note(lfsr[2*i +: 2]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch_level)
        begin
            case (level_num)
                4'd1, 4'd2, 4'd3:
                    level <= fixed_levels[level_num];
                default:
                    level <= {3'(max_notes), random_notes};
            endcase
        end
    end

endmodule

// ==== source/memory_game.sv ====
`timescale 1ns/1ps

module memory_game
    import game_pkg::*, display_pkg::*;
#(
    // half a second and one second at 50 MHz
    parameter int note_period = 25_000_000,
    parameter int pause_cycles = 50_000_000
)
(
    input logic clk,
    input logic load,
    input logic start,
    input level_num_t level_select,
    input note_t keys,
    output note_t leds,
    output display_t hex
);

    key_event_t key_event;
    logic next_level;
    logic fetch_level;
    level_num_t level_num;
    level_t level;
    game_status_t status;

    key_decoder u_key_decoder
    (
        .clk(clk),
        .load(load),
        .keys(keys),
        .key_event(key_event)
    );

    level_store u_level_store
    (
        .clk(clk),
        .load(load),
        .level_select(level_select),
        .next_level(next_level),
        .fetch_level(fetch_level),
        .level_num(level_num),
        .level(level)
    );

    game_controller #(
        .note_period(note_period),
        .pause_cycles(pause_cycles)
    ) u_game_controller
    (
        .clk(clk),
        .load(load),
        .start(start),
        .key_event(key_event),
        .level(level),
        .level_num(level_num),
        .next_level(next_level),
        .fetch_level(fetch_level),
        .leds(leds),
        .status(status)
    );

    display_driver u_display_driver
    (
        .status(status),
        .hex(hex)
    );

endmodule

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen
#(
    parameter int period_ns = 100
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(period_ns / 2) clk = ~clk;
    end

endmodule

// ==== tests/memory_game_tb.sv ====
`timescale 1ns/1ps

module memory_game_tb
    import game_pkg::*, display_pkg::*;
();

    localparam int note_period = 4;
    localparam int pause_cycles = 20;
    localparam int runs = 30;
    localparam int levels_per_run = 4;
    localparam int lost_hold = 60;
    // worst case cycles of one level with blanks, playback, six answers and the pause
    localparam int level_bound = 2 + 2 * note_period * max_notes + 16 * max_notes
        + pause_cycles + 10;
    localparam int run_bound = 10 + levels_per_run * level_bound + lost_hold;
    localparam int watchdog_ns = runs * run_bound * 100;

    logic clk;
    logic load;
    logic start;
    level_num_t level_select;
    note_t keys;
    note_t leds;
    display_t hex;

    int mismatches;
    int failures;
    int runs_done;
    // driven keys with the newest first
    note_t hist [$];
    note_t expected [$];
    note_t played [$];
    string expect_msg;
    int answer_idx;
    int won_cycles;

    clock_gen #(.period_ns(100)) u_clock_gen (.clk(clk));

    memory_game #(
        .note_period(note_period),
        .pause_cycles(pause_cycles)
    ) DUT
    (
        .clk(clk),
        .load(load),
        .start(start),
        .level_select(level_select),
        .keys(keys),
        .leds(leds),
        .hex(hex)
    );

    function automatic segments_t char_pattern(input byte c);
        case (c)
            "0": return hex_0;
            "1": return hex_1;
            "2": return hex_2;
            "3": return hex_3;
            "4": return hex_4;
            "5": return hex_5;
            "6": return hex_6;
            "7": return hex_7;
            "8": return hex_8;
            "9": return hex_9;
            "A": return pat_a;
            "b": return hex_b;
            "C": return pat_c;
            "d": return hex_d;
            "E": return pat_e;
            "F": return hex_f;
            "H": return pat_h;
            "L": return pat_l;
            "O": return pat_o;
            "S": return pat_s;
            "t": return pat_small_t;
            "G": return pat_g;
            "U": return pat_u;
            "r": return pat_small_r;
            "n": return pat_small_n;
            default: return pat_blank;
        endcase
    endfunction

    // leftmost character lands in digit 5
    function automatic display_t make_display(input string s);
        display_t d;
        for (int i = 0; i < 6; i++)
            d[5-i] = char_pattern(s[i]);
        return d;
    endfunction

    function automatic string level_digit(input int n);
        string digits;
        digits = "0123456789AbCdEF";
        return digits.substr(n, n);
    endfunction

    function automatic string fixed_sequence(input int lvl);
        case (lvl)
            1: return "1248";
            2: return "12211";
            default: return "421421";
        endcase
    endfunction

    function automatic int pick_between(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    function automatic note_t other_note(input note_t right);
        note_t pick;
        pick = note_t'(4'b0001 << ($urandom % 4));
        if (pick == right)
            pick = {pick[2:0], pick[3]};
        return pick;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        mismatches++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic drive_keys(input note_t value);
        keys = value;
        hist.push_front(value);
        void'(hist.pop_back());
    endtask

    task automatic reset_dut(input level_num_t sel);
        load = 1'b1;
        start = 1'b0;
        keys = '0;
        level_select = sel;
        hist.delete();
        repeat (4) hist.push_back('0);
        repeat (2) next_cycle();
        load = 1'b0;
    endtask

    // checks one cycle of the answer phase against the model
    task automatic check_cycle();
        bit press_seen;
        press_seen = (hist[2] != '0) && (hist[3] == '0);
        if (hex != make_display(expect_msg))
            report_mismatch($sformatf("display %h, expected \"%s\"", hex, expect_msg));
        if (expect_msg == "SCOrE ")
        begin
            if (leds != '0)
                report_mismatch($sformatf("leds %b during the win pause", leds));
            won_cycles++;
            if (won_cycles == pause_cycles)
                expect_msg = "      ";
        end
        else if (leds != hist[2])
            report_mismatch($sformatf("leds %b, keys three cycles earlier %b", leds, hist[2]));
        if (expect_msg == "UrtUrn" && press_seen)
        begin
            if (hist[2] != expected[answer_idx])
                expect_msg = "LOSE  ";
            else if (answer_idx == expected.size() - 1)
            begin
                expect_msg = "SCOrE ";
                won_cycles = 0;
            end
            else
                answer_idx++;
        end
    endtask

    task automatic tick(input note_t value);
        next_cycle();
        check_cycle();
        drive_keys(value);
    endtask

    task automatic record_level(input int lvl, output bit ok);
        int cycles;
        int blanks;
        int on_count;
        int off_count;
        bit done;
        note_t prev;
        display_t play_msg;
        ok = 1'b0;
        done = 1'b0;
        cycles = 0;
        blanks = 0;
        on_count = 0;
        off_count = 0;
        prev = '0;
        played.delete();
        play_msg = make_display({"StAGE", level_digit(lvl)});
        while (!done && cycles < level_bound)
        begin
            next_cycle();
            if (hex == make_display("UrtUrn") && played.size() > 0)
            begin
                if (off_count != note_period)
                    report_mismatch($sformatf("last gap lasted %0d cycles", off_count));
                ok = 1'b1;
                done = 1'b1;
            end
            else if (hex == play_msg)
            begin
                if (leds == '0)
                begin
                    if (prev != '0 && on_count != note_period)
                        report_mismatch($sformatf("note lasted %0d cycles", on_count));
                    off_count = (prev == '0) ? off_count + 1 : 1;
                end
                else if (prev == '0)
                begin
                    if (played.size() > 0 && off_count != note_period)
                        report_mismatch($sformatf("gap lasted %0d cycles", off_count));
                    played.push_back(leds);
                    on_count = 1;
                end
                else if (leds != prev)
                    report_mismatch($sformatf("note changed from %b to %b", prev, leds));
                else
                    on_count++;
            end
            else if (hex == make_display("      ") && played.size() == 0)
                blanks++;
            else
            begin
                report_mismatch($sformatf("display %h during level %0d playback", hex, lvl));
                done = 1'b1;
            end
            prev = leds;
            start = 1'b0;
            drive_keys('0);
            cycles++;
        end
        if (!done)
        begin
            failures++;
            $display("level %0d playback did not reach the answer phase in %0d cycles",
                lvl, level_bound);
        end
        if (blanks != 2)
            report_mismatch($sformatf("%0d blank cycles before playback, expected 2", blanks));
    endtask

    task automatic check_notes(input int lvl);
        string seq;
        expected.delete();
        if (lvl <= 3)
        begin
            seq = fixed_sequence(lvl);
            for (int i = 0; i < seq.len(); i++)
                expected.push_back(note_t'(seq[i] - 8'h30));
            for (int i = 0; i < played.size() && i < expected.size(); i++)
                if (played[i] != expected[i])
                    report_mismatch($sformatf("level %0d note %0d is %h, expected %h",
                        lvl, i, played[i], expected[i]));
        end
        else
        begin
            for (int i = 0; i < played.size(); i++)
                if (!$onehot(played[i]))
                    report_mismatch($sformatf("random note %0d is %b", i, played[i]));
            expected = played;
        end
        if (played.size() != ((lvl <= 3) ? seq.len() : max_notes))
            report_mismatch($sformatf("level %0d played %0d notes", lvl, played.size()));
    endtask

    task automatic hold_lost();
        repeat (lost_hold) tick(note_t'($urandom % 16));
    endtask

    task automatic answer_level(output bit won_level);
        bit wrong;
        int wrong_pos;
        int hold;
        int rel_cycles;
        note_t key;
        wrong = ($urandom % 2) == 1;
        wrong_pos = int'($urandom % expected.size());
        expect_msg = "UrtUrn";
        answer_idx = 0;
        won_cycles = 0;
        for (int i = 0; i < expected.size() && expect_msg == "UrtUrn"; i++)
        begin
            key = (wrong && i == wrong_pos) ? other_note(expected[i]) : expected[i];
            hold = pick_between(3, 8);
            rel_cycles = pick_between(3, 8);
            repeat (hold) tick(key);
            repeat (rel_cycles) tick('0);
        end
        won_level = (expect_msg != "LOSE  ");
        if (won_level)
        begin
            while (expect_msg == "SCOrE ")
                tick('0);
        end
        else
            hold_lost();
    endtask

    initial
    begin
        int sel;
        int lvl;
        int levels_done;
        bit playing;
        bit ok;
        bit won_level;
        mismatches = 0;
        failures = 0;
        runs_done = 0;
        void'($urandom(32'h8f91_741c));
        for (int run = 0; run < runs; run++)
        begin
            sel = pick_between(1, 5);
            reset_dut(level_num_t'(sel));
            for (int c = 0; c < 2; c++)
            begin
                next_cycle();
                if (hex != make_display("HELLO "))
                    report_mismatch($sformatf("display %h after reset", hex));
                if (leds != '0)
                    report_mismatch($sformatf("leds %b after reset with no key", leds));
            end
            start = 1'b1;
            lvl = (sel >= 15) ? 15 : sel + 1;
            levels_done = 0;
            playing = 1'b1;
            while (playing)
            begin
                record_level(lvl, ok);
                if (!ok)
                    playing = 1'b0;
                else
                begin
                    check_notes(lvl);
                    answer_level(won_level);
                    levels_done++;
                    if (!won_level || levels_done == levels_per_run)
                        playing = 1'b0;
                    else
                        lvl = (lvl == 15) ? 15 : lvl + 1;
                end
            end
            runs_done++;
        end
        $display("runs %0d, mismatches %0d, other failures %0d", runs_done, mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        failures++;
        $display("watchdog expired after %0d ns, the game did not finish its runs", watchdog_ns);
        $display("runs %0d, mismatches %0d, other failures %0d", runs_done, mismatches, failures);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
